// ==== src/dcache_pkg.sv ====
// dcache_pkg: cache geometry constants and the address, line, request and response structs
package dcache_pkg;

  // geometry
  localparam int NUM_WAY  = 4;
  localparam int NUM_SETS = 32;
  localparam int DATA_W   = 64;
  localparam int TAG_W    = 24;
  localparam int SET_W    = 5;
  localparam int OFFSET_W = 3;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [SET_W-1:0]    set_index;
    // byte offset, not used by the cache
    logic [OFFSET_W-1:0] offset;
  } addr_t;

  typedef struct packed {
    logic              valid;
    logic              dirty;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } line_t;

  typedef struct packed {
    logic  req;
    addr_t addr;
  } rd_req_t;

  // from_mem high means a fill, low means a store
  typedef struct packed {
    logic              req;
    logic              from_mem;
    addr_t             addr;
    logic [DATA_W-1:0] data;
    logic              dirty;
    logic              valid;
  } wr_req_t;

  typedef struct packed {
    logic              valid;
    logic              hit;
    logic [DATA_W-1:0] data;
  } rd_resp_t;

  typedef struct packed {
    logic valid;
    logic hit;
    logic written;
  } wr_resp_t;

  typedef struct packed {
    logic              valid;
    logic              dirty;
    addr_t             addr;
    logic [DATA_W-1:0] data;
  } evict_t;

  // one bit per way
  typedef logic [NUM_WAY-1:0] way_sel_t;

endpackage

// ==== src/dcache_req_stage.sv ====
// dcache_req_stage: request register in front of the lookup stage, with offset masking
`timescale 1ns/1ps

module dcache_req_stage (
  input  logic                clock,
  input  logic                reset,
  input  dcache_pkg::rd_req_t rd_req,
  input  dcache_pkg::wr_req_t wr_req,
  output dcache_pkg::rd_req_t rd_s,
  output dcache_pkg::wr_req_t wr_s
);

  import dcache_pkg::*;

  rd_req_t rd_next;
  wr_req_t wr_next;

  // offset bits never reach the array
  always_comb begin
    rd_next = rd_req;
    rd_next.addr.offset = '0;
    wr_next = wr_req;
    wr_next.addr.offset = '0;
  end

  // strobes
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_s.req <= 1'b0;
      wr_s.req <= 1'b0;
    end else begin
      rd_s.req <= rd_next.req;
      wr_s.req <= wr_next.req;
    end
  end

  // payload, only meaningful with the strobe
  always_ff @(posedge clock) begin
    rd_s.addr     <= rd_next.addr;
    wr_s.from_mem <= wr_next.from_mem;
    wr_s.addr     <= wr_next.addr;
    wr_s.data     <= wr_next.data;
    wr_s.dirty    <= wr_next.dirty;
    wr_s.valid    <= wr_next.valid;
  end

endmodule

// ==== src/dcache_way.sv ====
// dcache_way: line storage of one way with read and write tag compare and victim read-out
`timescale 1ns/1ps

module dcache_way (
  input  logic                           clock,
  input  logic                           reset,
  input  dcache_pkg::addr_t              rd_addr,
  input  dcache_pkg::addr_t              wr_addr,
  input  logic                           wr_en,
  input  dcache_pkg::line_t              wr_line,
  output logic                           rd_hit,
  output logic [dcache_pkg::DATA_W-1:0]  rd_data,
  output logic                           wr_hit,
  output dcache_pkg::line_t              victim_line
);

  import dcache_pkg::*;

  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;
  logic [TAG_W-1:0]    tag_q  [NUM_SETS];
  logic [DATA_W-1:0]   data_q [NUM_SETS];

  logic [SET_W-1:0] rd_set;
  logic [SET_W-1:0] wr_set;

  assign rd_set = rd_addr.set_index;
  assign wr_set = wr_addr.set_index;

  // read port lookup
  assign rd_hit  = valid_q[rd_set] && (tag_q[rd_set] == rd_addr.tag);
  assign rd_data = data_q[rd_set];

  // write port lookup
  assign wr_hit = valid_q[wr_set] && (tag_q[wr_set] == wr_addr.tag);

  // current line at the write set, old contents if this way gets replaced
  always_comb begin
    victim_line.valid = valid_q[wr_set];
    victim_line.dirty = dirty_q[wr_set];
    victim_line.tag   = tag_q[wr_set];
    victim_line.data  = data_q[wr_set];
  end

  // valid bits, all lines invalid after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_set] <= wr_line.valid;
    end
  end

  // line payload
  always_ff @(posedge clock) begin
    if (wr_en) begin
      dirty_q[wr_set] <= wr_line.dirty;
      tag_q[wr_set]   <= wr_line.tag;
      data_q[wr_set]  <= wr_line.data;
    end
  end

endmodule

// ==== src/dcache_plru.sv ====
// dcache_plru: per-set 3-bit tree pseudo-LRU with victim select and fill update
`timescale 1ns/1ps

module dcache_plru (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [dcache_pkg::SET_W-1:0]   set_index,
  input  logic                           fill,
  output dcache_pkg::way_sel_t           victim
);

  import dcache_pkg::*;

  // root bit a, left subtree b, right subtree c
  logic [NUM_SETS-1:0] a_q;
  logic [NUM_SETS-1:0] b_q;
  logic [NUM_SETS-1:0] c_q;

  logic a;
  logic b;
  logic c;

  assign a = a_q[set_index];
  assign b = b_q[set_index];
  assign c = c_q[set_index];

  // a picks the half, then b or c picks the way
  always_comb begin
    if (!a) begin
      victim = b ? way_sel_t'(4'b0010) : way_sel_t'(4'b0001);
    end else begin
      victim = c ? way_sel_t'(4'b1000) : way_sel_t'(4'b0100);
    end
  end

  // every fill flips the root and the subtree bit it pointed to
  always_ff @(posedge clock) begin
    if (reset) begin
      a_q <= '0;
      b_q <= '0;
      c_q <= '0;
    end else if (fill) begin
      a_q[set_index] <= ~a;
      if (!a) begin
        b_q[set_index] <= ~b;
      end else begin
        c_q[set_index] <= ~c;
      end
    end
  end

  // allocation order from reset is 0, 2, 1, 3

endmodule

// ==== src/dcache_core.sv ====
// dcache_core: four ways, PLRU, write-enable steering and victim line mux
`timescale 1ns/1ps

module dcache_core (
  input  logic                                                clock,
  input  logic                                                reset,
  input  dcache_pkg::rd_req_t                                 rd_s,
  input  dcache_pkg::wr_req_t                                 wr_s,
  output dcache_pkg::way_sel_t                                rd_hit,
  output logic [dcache_pkg::NUM_WAY-1:0][dcache_pkg::DATA_W-1:0] rd_data_way,
  output dcache_pkg::way_sel_t                                wr_hit,
  output dcache_pkg::way_sel_t                                victim,
  output dcache_pkg::line_t                                   victim_line
);

  import dcache_pkg::*;

  logic                 fill;
  logic                 store;
  way_sel_t             wr_en;
  line_t                wr_line;
  line_t [NUM_WAY-1:0]  way_line;

  assign fill  = wr_s.req & wr_s.from_mem;
  assign store = wr_s.req & ~wr_s.from_mem;

  // store writes the hit way only, fill rewrites a hit or takes the victim
  always_comb begin
    wr_en = '0;
    if (store) begin
      wr_en = wr_hit;
    end else if (fill) begin
      wr_en = (|wr_hit) ? wr_hit : victim;
    end
  end

  always_comb begin
    wr_line.valid = wr_s.valid;
    wr_line.dirty = wr_s.dirty;
    wr_line.tag   = wr_s.addr.tag;
    wr_line.data  = wr_s.data;
  end

  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    dcache_way u_way (
      .clock       (clock),
      .reset       (reset),
      .rd_addr     (rd_s.addr),
      .wr_addr     (wr_s.addr),
      .wr_en       (wr_en[w]),
      .wr_line     (wr_line),
      .rd_hit      (rd_hit[w]),
      .rd_data     (rd_data_way[w]),
      .wr_hit      (wr_hit[w]),
      .victim_line (way_line[w])
    );
  end

  dcache_plru u_plru (
    .clock     (clock),
    .reset     (reset),
    .set_index (wr_s.addr.set_index),
    .fill      (fill),
    .victim    (victim)
  );

  // one-hot select of the victim way's line
  always_comb begin
    victim_line = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (victim[w]) begin
        victim_line = way_line[w];
      end
    end
  end

endmodule

// ==== src/dcache_resp_stage.sv ====
// dcache_resp_stage: hit merge and registered read, write and eviction responses
`timescale 1ns/1ps

module dcache_resp_stage (
  input  logic                                                clock,
  input  logic                                                reset,
  input  dcache_pkg::rd_req_t                                 rd_s,
  input  dcache_pkg::wr_req_t                                 wr_s,
  input  dcache_pkg::way_sel_t                                rd_hit,
  input  logic [dcache_pkg::NUM_WAY-1:0][dcache_pkg::DATA_W-1:0] rd_data_way,
  input  dcache_pkg::way_sel_t                                wr_hit,
  input  dcache_pkg::way_sel_t                                victim,
  input  dcache_pkg::line_t                                   victim_line,
  output dcache_pkg::rd_resp_t                                rd_resp,
  output dcache_pkg::wr_resp_t                                wr_resp,
  output dcache_pkg::evict_t                                  evict
);

  import dcache_pkg::*;

  logic              rd_any_hit;
  logic              wr_any_hit;
  logic              fill;
  logic              store;
  logic              fill_miss;
  logic              written;
  logic              evict_now;
  logic [DATA_W-1:0] rd_word;
  addr_t             evict_addr;

  assign rd_any_hit = rd_s.req & (|rd_hit);
  assign wr_any_hit = wr_s.req & (|wr_hit);

  // data of the hitting way, zero on a miss
  always_comb begin
    rd_word = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (rd_hit[w]) begin
        rd_word = rd_word | rd_data_way[w];
      end
    end
  end

  assign fill      = wr_s.req & wr_s.from_mem;
  assign store     = wr_s.req & ~wr_s.from_mem;
  assign fill_miss = fill & ~(|wr_hit);

  // a fill miss lands in the PLRU victim way
  assign written   = (store & wr_any_hit) | (fill & wr_any_hit) | (fill_miss & (|victim));
  assign evict_now = fill_miss & (|victim) & victim_line.valid;

  // evicted address rebuilt from the stored tag and the write set
  always_comb begin
    evict_addr.tag       = victim_line.tag;
    evict_addr.set_index = wr_s.addr.set_index;
    evict_addr.offset    = '0;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_resp.valid   <= 1'b0;
      rd_resp.hit     <= 1'b0;
      wr_resp         <= '0;
      evict.valid     <= 1'b0;
    end else begin
      rd_resp.valid   <= rd_s.req;
      rd_resp.hit     <= rd_any_hit;
      wr_resp.valid   <= wr_s.req;
      wr_resp.hit     <= wr_any_hit;
      wr_resp.written <= written;
      evict.valid     <= evict_now;
    end
  end

  always_ff @(posedge clock) begin
    rd_resp.data <= rd_any_hit ? rd_word : '0;
    evict.dirty  <= victim_line.dirty;
    evict.addr   <= evict_addr;
    evict.data   <= victim_line.data;
  end

endmodule

// ==== src/dcache_top.sv ====
// dcache_top: request stage, cache core and response stage of the data cache
`timescale 1ns/1ps

module dcache_top (
  input  logic                 clock,
  input  logic                 reset,
  input  dcache_pkg::rd_req_t  rd_req,
  input  dcache_pkg::wr_req_t  wr_req,
  output dcache_pkg::rd_resp_t rd_resp,
  output dcache_pkg::wr_resp_t wr_resp,
  output dcache_pkg::evict_t   evict
);

  import dcache_pkg::*;

  rd_req_t                          rd_s;
  wr_req_t                          wr_s;
  way_sel_t                         rd_hit;
  way_sel_t                         wr_hit;
  way_sel_t                         victim;
  line_t                            victim_line;
  logic [NUM_WAY-1:0][DATA_W-1:0]   rd_data_way;

  // edge k
  dcache_req_stage u_req_stage (
    .clock  (clock),
    .reset  (reset),
    .rd_req (rd_req),
    .wr_req (wr_req),
    .rd_s   (rd_s),
    .wr_s   (wr_s)
  );

  // lookup in cycle k..k+1, array write at edge k+1
  dcache_core u_core (
    .clock       (clock),
    .reset       (reset),
    .rd_s        (rd_s),
    .wr_s        (wr_s),
    .rd_hit      (rd_hit),
    .rd_data_way (rd_data_way),
    .wr_hit      (wr_hit),
    .victim      (victim),
    .victim_line (victim_line)
  );

  // responses at edge k+1
  dcache_resp_stage u_resp_stage (
    .clock       (clock),
    .reset       (reset),
    .rd_s        (rd_s),
    .wr_s        (wr_s),
    .rd_hit      (rd_hit),
    .rd_data_way (rd_data_way),
    .wr_hit      (wr_hit),
    .victim      (victim),
    .victim_line (victim_line),
    .rd_resp     (rd_resp),
    .wr_resp     (wr_resp),
    .evict       (evict)
  );

endmodule

// ==== verif/dcache_chk.sv ====
// dcache_chk: concurrent assertions on the cache responses and their bind to dcache_top
`timescale 1ns/1ps

module dcache_chk (
  input logic                 clock,
  input logic                 reset,
  input dcache_pkg::rd_resp_t rd_resp,
  input dcache_pkg::wr_resp_t wr_resp,
  input dcache_pkg::evict_t   evict
);

  // number of failed assertions
  int n_fail;

  // a hit only comes with a valid read response
  a_rd_hit_valid: assert property (@(posedge clock) disable iff (reset)
    rd_resp.hit |-> rd_resp.valid)
    else begin
      $error("read hit reported without a valid read response");
      n_fail++;
    end

  // an eviction belongs to a fill that was written
  a_evict_written: assert property (@(posedge clock) disable iff (reset)
    evict.valid |-> (wr_resp.valid && wr_resp.written))
    else begin
      $error("eviction without a written write response");
      n_fail++;
    end

  // strobes cleared by the reset edge
  a_reset_strobes: assert property (@(posedge clock)
    reset |=> (!rd_resp.valid && !wr_resp.valid && !evict.valid))
    else begin
      $error("response strobe high during reset");
      n_fail++;
    end

endmodule

bind dcache_top dcache_chk u_chk (
  .clock   (clock),
  .reset   (reset),
  .rd_resp (rd_resp),
  .wr_resp (wr_resp),
  .evict   (evict)
);

// ==== verif/dcache_tb.sv ====
// dcache_tb: data-file driven testbench with random read filler, response checks and watchdog
`timescale 1ns/1ps

module dcache_tb;

  import dcache_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_RAND     = 32;

  logic     clock;
  logic     reset;
  rd_req_t  rd_req;
  wr_req_t  wr_req;
  rd_resp_t rd_resp;
  wr_resp_t wr_resp;
  evict_t   evict;

  // stimulus from the data file
  rd_req_t  rd_stim_q [$];
  wr_req_t  wr_stim_q [$];
  // expected responses in issue order
  rd_resp_t rd_exp_q [$];
  wr_resp_t wr_exp_q [$];
  evict_t   ev_exp_q [$];

  int   seed;
  int   n_lines;
  logic loaded;

  dcache_top u_dut (
    .clock   (clock),
    .reset   (reset),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_resp (rd_resp),
    .wr_resp (wr_resp),
    .evict   (evict)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic fail_run(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic push_idle();
    rd_exp_q.push_back('0);
    wr_exp_q.push_back('0);
    ev_exp_q.push_back('0);
  endtask

  task automatic load_testdata();
    int          fd;
    int          n;
    string       line;
    logic [63:0] f [18];
    rd_req_t     rd;
    wr_req_t     wr;
    rd_resp_t    er;
    wr_resp_t    ew;
    evict_t      ee;
    fd = $fopen("verif/dcache_testdata.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the test data file verif/dcache_testdata.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
        if (n == 18) begin
          rd = '{req: f[0][0], addr: f[1][31:0]};
          wr = '{req: f[2][0], from_mem: f[3][0], addr: f[4][31:0], data: f[5],
                 dirty: f[6][0], valid: f[7][0]};
          er = '{valid: f[8][0], hit: f[9][0], data: f[10]};
          ew = '{valid: f[11][0], hit: f[12][0], written: f[13][0]};
          ee = '{valid: f[14][0], dirty: f[15][0], addr: f[16][31:0], data: f[17]};
          rd_stim_q.push_back(rd);
          wr_stim_q.push_back(wr);
          rd_exp_q.push_back(er);
          wr_exp_q.push_back(ew);
          ev_exp_q.push_back(ee);
        end else if (n > 0) begin
          fail_run($sformatf("test data line has %0d fields instead of 18", n));
        end
      end
    end
    $fclose(fd);
    n_lines = rd_stim_q.size();
  endtask

  // payload fields only matter when the expected strobe is set
  task automatic check_responses(input int cycle);
    rd_resp_t er;
    wr_resp_t ew;
    evict_t   ee;
    er = rd_exp_q.pop_front();
    ew = wr_exp_q.pop_front();
    ee = ev_exp_q.pop_front();
    assert (rd_resp.valid === er.valid && (!er.valid || rd_resp === er))
      else fail_run($sformatf("cycle %0d read response %h, expected %h", cycle, rd_resp, er));
    assert (wr_resp.valid === ew.valid && (!ew.valid || wr_resp === ew))
      else fail_run($sformatf("cycle %0d write response %b, expected %b", cycle, wr_resp, ew));
    assert (evict.valid === ee.valid && (!ee.valid || evict === ee))
      else fail_run($sformatf("cycle %0d evict %h, expected %h", cycle, evict, ee));
    assert (u_dut.u_chk.n_fail == 0)
      else fail_run("a bound assertion on the responses failed");
  endtask

  initial begin
    int      total;
    rd_req_t rd;
    rd_resp_t er;
    seed        = 64483;
    reset       = 1'b1;
    rd_req      = '0;
    wr_req      = '0;
    loaded      = 1'b0;
    // two cycles pass before the first request answers
    push_idle();
    push_idle();
    load_testdata();
    loaded = 1'b1;
    total  = n_lines + NUM_RAND;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;
    for (int i = 0; i < total + 2; i++) begin
      @(posedge clock);
      #1;
      check_responses(i);
      if (i < n_lines) begin
        rd_req = rd_stim_q[i];
        wr_req = wr_stim_q[i];
      end else if (i < total) begin
        // tags starting with ee are never filled
        rd.req            = 1'b1;
        rd.addr.tag       = {8'hee, 16'($random(seed))};
        rd.addr.set_index = 5'($random(seed));
        rd.addr.offset    = 3'($random(seed));
        rd_req = rd;
        wr_req = '0;
        er = '0;
        er.valid = 1'b1;
        rd_exp_q.push_back(er);
        wr_exp_q.push_back('0);
        ev_exp_q.push_back('0);
      end else begin
        rd_req = '0;
        wr_req = '0;
        push_idle();
      end
    end
    $display("TEST OK");
    $finish;
  end

  // run length bound from the number of data lines
  initial begin
    wait (loaded === 1'b1);
    #((n_lines + 100) * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before all responses were checked");
  end

endmodule

// ==== dcache.f ====
src/dcache_pkg.sv
src/dcache_req_stage.sv
src/dcache_way.sv
src/dcache_plru.sv
src/dcache_core.sv
src/dcache_resp_stage.sv
src/dcache_top.sv
verif/dcache_chk.sv
verif/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/dcache_req_stage.sv
  - src/dcache_way.sv
  - src/dcache_plru.sv
  - src/dcache_core.sv
  - src/dcache_resp_stage.sv
  - src/dcache_top.sv
  - target: test
    files:
      - verif/dcache_chk.sv
      - verif/dcache_tb.sv

// ==== verif/dcache_testdata.txt ====
# rd_req rd_addr wr_req from_mem wr_addr wr_data wr_dirty wr_valid, then expected
# rd_valid rd_hit rd_data  wr_valid wr_hit written  ev_valid ev_dirty ev_addr ev_data
# read miss after reset
1 000a0118 0 0 00000000 0 0 0   1 0 0     0 0 0   0 0 00000000 0
# fills to set 3 land in ways 0 2 1 3
0 00000000 1 1 000a0118 11 0 1   0 0 0    1 0 1   0 0 00000000 0
0 00000000 1 1 000a0218 22 0 1   0 0 0    1 0 1   0 0 00000000 0
0 00000000 1 1 000a0318 33 0 1   0 0 0    1 0 1   0 0 00000000 0
0 00000000 1 1 000a0418 44 0 1   0 0 0    1 0 1   0 0 00000000 0
# read back the filled tags
1 000a0118 0 0 00000000 0 0 0   1 1 11    0 0 0   0 0 00000000 0
1 000a021c 0 0 00000000 0 0 0   1 1 22    0 0 0   0 0 00000000 0
1 000a0318 0 0 00000000 0 0 0   1 1 33    0 0 0   0 0 00000000 0
1 000a0418 0 0 00000000 0 0 0   1 1 44    0 0 0   0 0 00000000 0
# store hit then store miss
0 00000000 1 0 000a0118 5a5a 1 1   0 0 0  1 1 1   0 0 00000000 0
1 000a0118 0 0 00000000 0 0 0   1 1 5a5a  0 0 0   0 0 00000000 0
0 00000000 1 0 000a0f18 dead 1 1   0 0 0  1 0 0   0 0 00000000 0
1 000a0f18 0 0 00000000 0 0 0   1 0 0     0 0 0   0 0 00000000 0
# fifth and sixth fill evict ways 0 and 2
0 00000000 1 1 000a0518 55 0 1   0 0 0    1 0 1   1 1 000a0118 5a5a
0 00000000 1 1 000a0618 66 0 1   0 0 0    1 0 1   1 0 000a0218 22
1 000a0118 0 0 00000000 0 0 0   1 0 0     0 0 0   0 0 00000000 0
1 000a0518 0 0 00000000 0 0 0   1 1 55    0 0 0   0 0 00000000 0
0 00000000 0 0 00000000 0 0 0   0 0 0     0 0 0   0 0 00000000 0
# read and fill of one address in the same cycle
1 00b00138 1 1 00b00138 77 0 1   1 0 0    1 0 1   0 0 00000000 0
1 00b0013b 0 0 00000000 0 0 0   1 1 77    0 0 0   0 0 00000000 0
0 00000000 1 1 00b00138 78 0 1   0 0 0    1 1 1   0 0 00000000 0
1 00b00138 0 0 00000000 0 0 0   1 1 78    0 0 0   0 0 00000000 0
# read and store on both ports
1 000a0618 1 0 000a0518 99 1 1   1 1 66   1 1 1   0 0 00000000 0
1 000a051f 0 0 00000000 0 0 0   1 1 99    0 0 0   0 0 00000000 0
